// ==== Bender.yml ====
package:
  name: drbg_upd

sources:
  - include_dirs:
      - common
    files:
      - common/drbg_ctrl_pkg.sv
      - common/drbg_data_pkg.sv
  - include_dirs:
      - common
    files:
      - design/drbg_stage_reg.sv
      - design/upd/drbg_upd_sender.sv
      - design/upd/drbg_upd_collector.sv
      - design/drbg_upd_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/drbg_upd_checker.sv
      - sim/tb_drbg_upd.sv

// ==== common/drbg_cfg.svh ====
// sizes fixed for a 256-bit security strength; the counter must stay narrower than a block
`ifndef DRBG_CFG_SVH
`define DRBG_CFG_SVH

// ------------------------------------------------------------------------
// record field widths
// ------------------------------------------------------------------------

// command code and instance id, passed through untouched
`define DRBG_CMD_W 3
`define DRBG_ID_W 4

// cipher block, also the width of V
`define DRBG_BLK_W 128

// cipher key
`define DRBG_KEY_W 256

// provided data and joined cipher output, key plus V
`define DRBG_SEED_W 384

// ------------------------------------------------------------------------
// update sequencing
// ------------------------------------------------------------------------

// only the low part of V counts, upper bits pass through
`define DRBG_CTR_W 32

// seed width over block width
`define DRBG_BLKS_PER_SEED 3

`endif

// ==== common/drbg_ctrl_pkg.sv ====
// plain binary state codes; command codes are carried as given and never checked
`default_nettype none

`include "drbg_cfg.svh"

package drbg_ctrl_pkg;

  // application command codes
  typedef enum logic [`DRBG_CMD_W-1:0] {
    CmdIns = 3'd1,
    CmdRes = 3'd2,
    CmdGen = 3'd3,
    CmdUpd = 3'd4,
    CmdUni = 3'd5
  } drbg_cmd_e;

  // ------------------------------------------------------------------------
  // state machines of the update block
  // ------------------------------------------------------------------------

  // request side, feeds the cipher
  typedef enum logic [1:0] {
    SendIdle   = 2'd0,
    SendBlocks = 2'd1,
    EsHalt     = 2'd2
  } sender_state_e;

  // response side, builds the new key and V
  typedef enum logic [1:0] {
    CollIdle  = 2'd0,
    CollLoad  = 2'd1,
    CollShift = 2'd2
  } collector_state_e;

endpackage

`default_nettype wire

// ==== common/drbg_data_pkg.sv ====
// record layouts follow the cfg widths; field order is part of the external interface
`default_nettype none

`include "drbg_cfg.svh"

package drbg_data_pkg;

  import drbg_ctrl_pkg::*;

  // ------------------------------------------------------------------------
  // update channel
  // ------------------------------------------------------------------------

  // incoming update request, 775 bits
  typedef struct packed {
    drbg_cmd_e                cmd;
    logic [`DRBG_ID_W-1:0]    inst_id;
    logic [`DRBG_SEED_W-1:0]  pdata;
    logic [`DRBG_KEY_W-1:0]   key;
    logic [`DRBG_BLK_W-1:0]   v;
  } upd_req_t;

  // finished update, 391 bits
  typedef struct packed {
    drbg_cmd_e                cmd;
    logic [`DRBG_ID_W-1:0]    inst_id;
    logic [`DRBG_KEY_W-1:0]   key;
    logic [`DRBG_BLK_W-1:0]   v;
  } upd_rsp_t;

  // ------------------------------------------------------------------------
  // block cipher channel
  // ------------------------------------------------------------------------

  // one block to encrypt, 391 bits
  typedef struct packed {
    drbg_cmd_e                cmd;
    logic [`DRBG_ID_W-1:0]    inst_id;
    logic [`DRBG_KEY_W-1:0]   key;
    logic [`DRBG_BLK_W-1:0]   v;
  } benc_req_t;

  // encrypted block back from the cipher, 135 bits
  typedef struct packed {
    drbg_cmd_e                cmd;
    logic [`DRBG_ID_W-1:0]    inst_id;
    logic [`DRBG_BLK_W-1:0]   v;
  } benc_rsp_t;

endpackage

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/drbg_ctrl_pkg.sv
common/drbg_data_pkg.sv
design/drbg_stage_reg.sv
design/upd/drbg_upd_sender.sv
design/upd/drbg_upd_collector.sv
design/drbg_upd_top.sv
sim/drbg_upd_checker.sv
sim/tb_drbg_upd.sv

// ==== design/drbg_stage_reg.sv ====
// single entry; a push while full is dropped, so callers push only when full_o is low
`timescale 1ns/10ps
`default_nettype none

module drbg_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clr_i,
  input  logic     push_i,
  input  logic     pop_i,
  input  payload_t data_i,
  output payload_t data_o,
  output logic     full_o
);

  logic     full_q;
  payload_t data_q;

  // occupancy flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (clr_i) begin
      full_q <= 1'b0;
    end else if (push_i && !full_q) begin
      full_q <= 1'b1;
    end else if (pop_i) begin
      full_q <= 1'b0;
    end
  end

  // payload, only written when the slot is free
  always_ff @(posedge clk_i) begin
    if (push_i && !full_q) begin
      data_q <= data_i;
    end
  end

  assign data_o = data_q;
  assign full_o = full_q;

endmodule

`default_nettype wire

// ==== design/drbg_upd_top.sv ====
// block cipher is external; upd_ack_o is itself the result transfer, no separate valid
`timescale 1ns/10ps
`default_nettype none

`include "drbg_cfg.svh"

module drbg_upd_top
  import drbg_data_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      enable_i,
  // update request
  input  logic      upd_valid_i,
  input  upd_req_t  upd_req_i,
  output logic      upd_rdy_o,
  // update result
  output upd_rsp_t  upd_rsp_o,
  output logic      upd_ack_o,
  input  logic      upd_rdy_i,
  // entropy source halt
  input  logic      es_req_i,
  output logic      es_ack_o,
  // block cipher
  output logic      benc_valid_o,
  output benc_req_t benc_req_o,
  input  logic      benc_rdy_i,
  input  logic      benc_ack_i,
  input  benc_rsp_t benc_rsp_i,
  output logic      benc_rdy_o
);

  logic      stage_clr;
  upd_req_t  req_data;
  logic      req_full;
  logic      req_pop;
  benc_req_t benc_wdata;
  logic      benc_push;
  logic      benc_full;
  benc_rsp_t rsp_data;
  logic      rsp_full;
  logic      rsp_pop;
  logic [`DRBG_SEED_W-1:0] pdata_data;
  logic      pdata_push;
  logic      pdata_pop;
  logic      pdata_full;
  upd_rsp_t  final_wdata;
  logic      final_push;
  logic      final_full;

  assign stage_clr    = ~enable_i;
  assign upd_rdy_o    = ~req_full;
  assign benc_valid_o = benc_full;
  assign benc_rdy_o   = ~rsp_full;
  assign upd_ack_o    = final_full & upd_rdy_i;

  // ------------------------------------------------------------------------
  // staging registers
  // ------------------------------------------------------------------------

  drbg_stage_reg #(.payload_t(upd_req_t)) u_req_stage (
    .clk_i, .rst_ni, .clr_i(stage_clr), .push_i(upd_valid_i), .pop_i(req_pop),
    .data_i(upd_req_i), .data_o(req_data), .full_o(req_full)
  );

  drbg_stage_reg #(.payload_t(benc_req_t)) u_benc_stage (
    .clk_i, .rst_ni, .clr_i(stage_clr), .push_i(benc_push), .pop_i(benc_full & benc_rdy_i),
    .data_i(benc_wdata), .data_o(benc_req_o), .full_o(benc_full)
  );

  drbg_stage_reg #(.payload_t(benc_rsp_t)) u_rsp_stage (
    .clk_i, .rst_ni, .clr_i(stage_clr), .push_i(benc_ack_i), .pop_i(rsp_pop),
    .data_i(benc_rsp_i), .data_o(rsp_data), .full_o(rsp_full)
  );

  // provided data waits here while the cipher works
  drbg_stage_reg #(.payload_t(logic [`DRBG_SEED_W-1:0])) u_pdata_stage (
    .clk_i, .rst_ni, .clr_i(stage_clr), .push_i(pdata_push), .pop_i(pdata_pop),
    .data_i(req_data.pdata), .data_o(pdata_data), .full_o(pdata_full)
  );

  drbg_stage_reg #(.payload_t(upd_rsp_t)) u_final_stage (
    .clk_i, .rst_ni, .clr_i(stage_clr), .push_i(final_push), .pop_i(upd_ack_o),
    .data_i(final_wdata), .data_o(upd_rsp_o), .full_o(final_full)
  );

  // ------------------------------------------------------------------------
  // request and response sides
  // ------------------------------------------------------------------------

  drbg_upd_sender u_sender (
    .clk_i, .rst_ni, .enable_i, .es_req_i, .es_ack_o,
    .req_full_i(req_full), .req_i(req_data), .req_pop_o(req_pop),
    .pdata_full_i(pdata_full), .pdata_push_o(pdata_push),
    .benc_full_i(benc_full), .benc_push_o(benc_push), .benc_o(benc_wdata)
  );

  drbg_upd_collector u_collector (
    .clk_i, .rst_ni, .enable_i,
    .rsp_full_i(rsp_full), .rsp_i(rsp_data), .rsp_pop_o(rsp_pop),
    .pdata_full_i(pdata_full), .pdata_i(pdata_data), .pdata_pop_o(pdata_pop),
    .final_full_i(final_full), .final_push_o(final_push), .final_o(final_wdata)
  );

endmodule

`default_nettype wire

// ==== design/upd/drbg_upd_collector.sv ====
// expects cipher responses in issue order; cmd and id of the last block are passed on
`timescale 1ns/10ps
`default_nettype none

`include "drbg_cfg.svh"

module drbg_upd_collector
  import drbg_ctrl_pkg::*;
  import drbg_data_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    rsp_full_i,
  input  benc_rsp_t               rsp_i,
  output logic                    rsp_pop_o,
  input  logic                    pdata_full_i,
  input  logic [`DRBG_SEED_W-1:0] pdata_i,
  output logic                    pdata_pop_o,
  input  logic                    final_full_i,
  output logic                    final_push_o,
  output upd_rsp_t                final_o
);

  collector_state_e            state_q, state_d;
  logic [1:0]                  cnt_q;
  logic                        cnt_inc;
  logic                        blks_done;
  logic                        outblk_shift;
  logic [`DRBG_SEED_W-1:0]     outblk_q;
  logic [`DRBG_SEED_W-1:0]     key_and_v;
  drbg_cmd_e                   cmd_q;
  logic [`DRBG_ID_W-1:0]       inst_id_q;

  assign blks_done = (cnt_q == 2'(`DRBG_BLKS_PER_SEED));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CollIdle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (!enable_i || final_push_o) begin
        cnt_q <= '0;
      end else if (cnt_inc) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // output block shift register
  // ------------------------------------------------------------------------

  // new block goes in at the bottom, earlier ones move up
  always_ff @(posedge clk_i) begin
    if (rsp_pop_o) begin
      outblk_q  <= {outblk_q[`DRBG_SEED_W-1:`DRBG_BLK_W], rsp_i.v};
      cmd_q     <= rsp_i.cmd;
      inst_id_q <= rsp_i.inst_id;
    end else if (outblk_shift) begin
      outblk_q <= {outblk_q[`DRBG_SEED_W-`DRBG_BLK_W-1:0], {`DRBG_BLK_W{1'b0}}};
    end
  end

  // key from the top, V from the bottom
  assign key_and_v       = outblk_q ^ pdata_i;
  assign final_o.cmd     = cmd_q;
  assign final_o.inst_id = inst_id_q;
  assign final_o.key     = key_and_v[`DRBG_SEED_W-1 -: `DRBG_KEY_W];
  assign final_o.v       = key_and_v[`DRBG_BLK_W-1:0];

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------

  always_comb begin
    state_d      = state_q;
    cnt_inc      = 1'b0;
    outblk_shift = 1'b0;
    rsp_pop_o    = 1'b0;
    pdata_pop_o  = 1'b0;
    final_push_o = 1'b0;
    unique case (state_q)
      CollIdle: begin
        // result slot must be free before starting
        if (enable_i && rsp_full_i && pdata_full_i && !final_full_i) begin
          state_d = CollLoad;
        end
      end
      CollLoad: begin
        if (!enable_i) begin
          state_d = CollIdle;
        end else if (rsp_full_i) begin
          rsp_pop_o = 1'b1;
          cnt_inc   = 1'b1;
          state_d   = CollShift;
        end
      end
      CollShift: begin
        if (!enable_i) begin
          state_d = CollIdle;
        end else if (blks_done) begin
          pdata_pop_o  = 1'b1;
          final_push_o = 1'b1;
          state_d      = CollIdle;
        end else begin
          outblk_shift = 1'b1;
          state_d      = CollLoad;
        end
      end
      default: begin
        state_d = CollIdle;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/upd/drbg_upd_sender.sv ====
// issues the blocks of one update at a time; a halt request is only taken while idle
`timescale 1ns/10ps
`default_nettype none

`include "drbg_cfg.svh"

module drbg_upd_sender
  import drbg_ctrl_pkg::*;
  import drbg_data_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      enable_i,
  input  logic      es_req_i,
  output logic      es_ack_o,
  input  logic      req_full_i,
  input  upd_req_t  req_i,
  output logic      req_pop_o,
  input  logic      pdata_full_i,
  output logic      pdata_push_o,
  input  logic      benc_full_i,
  output logic      benc_push_o,
  output benc_req_t benc_o
);

  sender_state_e           state_q, state_d;
  logic [`DRBG_CTR_W-1:0]  ctr_q;
  logic [1:0]              iter_q;
  logic                    ctr_load;
  logic                    ctr_inc;
  logic                    blks_done;

  assign blks_done = (iter_q == 2'(`DRBG_BLKS_PER_SEED));

  // ------------------------------------------------------------------------
  // V counter and block count
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SendIdle;
      ctr_q   <= '0;
      iter_q  <= '0;
    end else begin
      state_q <= state_d;
      if (!enable_i) begin
        ctr_q  <= '0;
        iter_q <= '0;
      end else if (ctr_load) begin
        // first block already uses V plus one
        ctr_q  <= req_i.v[`DRBG_CTR_W-1:0] + 1'b1;
        iter_q <= '0;
      end else if (ctr_inc) begin
        ctr_q  <= ctr_q + 1'b1;
        iter_q <= iter_q + 1'b1;
      end
    end
  end

  // upper part of V is never touched
  assign benc_o.cmd     = req_i.cmd;
  assign benc_o.inst_id = req_i.inst_id;
  assign benc_o.key     = req_i.key;
  assign benc_o.v       = {req_i.v[`DRBG_BLK_W-1:`DRBG_CTR_W], ctr_q};

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------

  always_comb begin
    state_d      = state_q;
    ctr_load     = 1'b0;
    ctr_inc      = 1'b0;
    pdata_push_o = 1'b0;
    benc_push_o  = 1'b0;
    req_pop_o    = 1'b0;
    es_ack_o     = 1'b0;
    unique case (state_q)
      SendIdle: begin
        // halt wins so the entropy source is not starved
        if (es_req_i) begin
          state_d = EsHalt;
        end else if (enable_i && req_full_i && !pdata_full_i && !benc_full_i) begin
          ctr_load     = 1'b1;
          pdata_push_o = 1'b1;
          state_d      = SendBlocks;
        end
      end
      SendBlocks: begin
        if (!enable_i) begin
          state_d = SendIdle;
        end else if (blks_done) begin
          req_pop_o = 1'b1;
          state_d   = SendIdle;
        end else if (!benc_full_i) begin
          benc_push_o = 1'b1;
          ctr_inc     = 1'b1;
        end
      end
      EsHalt: begin
        es_ack_o = 1'b1;
        if (!es_req_i) begin
          state_d = SendIdle;
        end
      end
      default: begin
        state_d = SendIdle;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== sim/drbg_upd_checker.sv ====
// model uses the same xor and rotate cipher stand-in as the testbench, not a real block cipher
`timescale 1ns/10ps
`default_nettype none

`include "drbg_cfg.svh"

module drbg_upd_checker
  import drbg_ctrl_pkg::*;
  import drbg_data_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     enable_i,
  input  logic     req_valid_i,
  input  logic     req_rdy_i,
  input  upd_req_t req_i,
  input  logic     ack_i,
  input  upd_rsp_t rsp_i,
  output int       res_cnt_o,
  output int       err_cnt_o
);

  upd_rsp_t exp_q[$];
  int       res_cnt = 0;
  int       err_cnt = 0;

  assign res_cnt_o = res_cnt;
  assign err_cnt_o = err_cnt;

  // stand-in cipher xors with the low key half and rotates left by one byte
  function automatic logic [`DRBG_BLK_W-1:0] cipher_model(input logic [`DRBG_KEY_W-1:0] key,
                                                          input logic [`DRBG_BLK_W-1:0] v);
    logic [`DRBG_BLK_W-1:0] x;
    x = v ^ key[`DRBG_BLK_W-1:0];
    return {x[`DRBG_BLK_W-9:0], x[`DRBG_BLK_W-1 -: 8]};
  endfunction

  // ------------------------------------------------------------------------
  // expected key and V for one request
  // ------------------------------------------------------------------------

  function automatic upd_rsp_t expected_result(input upd_req_t req);
    upd_rsp_t                rsp;
    logic [`DRBG_SEED_W-1:0] joined;
    logic [`DRBG_BLK_W-1:0]  v_blk;
    logic [`DRBG_CTR_W-1:0]  low;
    int                      i;
    joined = '0;
    for (i = 1; i <= `DRBG_BLKS_PER_SEED; i++) begin
      low    = req.v[`DRBG_CTR_W-1:0] + `DRBG_CTR_W'(i);
      v_blk  = {req.v[`DRBG_BLK_W-1:`DRBG_CTR_W], low};
      // first block ends up on top
      joined = {joined[`DRBG_SEED_W-`DRBG_BLK_W-1:0], cipher_model(req.key, v_blk)};
    end
    joined      = joined ^ req.pdata;
    rsp.cmd     = req.cmd;
    rsp.inst_id = req.inst_id;
    rsp.key     = joined[`DRBG_SEED_W-1 -: `DRBG_KEY_W];
    rsp.v       = joined[`DRBG_BLK_W-1:0];
    return rsp;
  endfunction

  task automatic compare_result(input upd_rsp_t got);
    upd_rsp_t want;
    res_cnt++;
    if (exp_q.size() == 0) begin
      $display("result at %0t ns arrived with no request outstanding", $time);
      err_cnt++;
    end else begin
      want = exp_q.pop_front();
      if (got.cmd !== want.cmd) begin
        $display("ERR upd_rsp_o.cmd exp=%h got=%h", want.cmd, got.cmd);
        err_cnt++;
      end
      if (got.inst_id !== want.inst_id) begin
        $display("ERR upd_rsp_o.inst_id exp=%h got=%h", want.inst_id, got.inst_id);
        err_cnt++;
      end
      if (got.key !== want.key) begin
        $display("ERR upd_rsp_o.key exp=%h got=%h", want.key, got.key);
        err_cnt++;
      end
      if (got.v !== want.v) begin
        $display("ERR upd_rsp_o.v exp=%h got=%h", want.v, got.v);
        err_cnt++;
      end
    end
  endtask

  // disable drops everything in flight
  always @(posedge clk_i) begin
    if (!rst_ni || !enable_i) begin
      exp_q.delete();
    end else begin
      if (ack_i) begin
        compare_result(rsp_i);
      end
      if (req_valid_i && req_rdy_i) begin
        exp_q.push_back(expected_result(req_i));
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_drbg_upd.sv ====
// cipher stand-in is xor and rotate only, answering in order; all waits end by their own timeout
`timescale 1ns/10ps
`default_nettype none

`include "drbg_cfg.svh"

module tb_drbg_upd
  import drbg_ctrl_pkg::*;
  import drbg_data_pkg::*;
();

  localparam int wait_limit = 5000;

  logic      clk;
  logic      rst_n;
  logic      enable;
  logic      upd_valid;
  upd_req_t  upd_req;
  logic      req_rdy;
  upd_rsp_t  upd_rsp;
  logic      upd_ack;
  logic      res_rdy = 1'b1;
  logic      es_req;
  logic      es_ack;
  logic      benc_valid;
  benc_req_t benc_req;
  logic      benc_rdy = 1'b1;
  logic      benc_ack = 1'b0;
  benc_rsp_t benc_rsp = '0;
  logic      rsp_rdy;
  int        seed = 71683;
  int        chk_res;
  int        chk_err;
  int        tb_err = 0;
  int        test_errs = 0;
  int        tests_run = 0;
  int        tests_bad = 0;
  int        expected = 0;
  logic      stress = 1'b0;
  // cipher stand-in state
  benc_req_t cipher_q[$];
  benc_req_t taken_req;
  logic      en_seen = 1'b0;
  logic      benc_taken = 1'b0;
  logic      rsp_taken = 1'b0;
  int        rsp_delay = 0;

  drbg_upd_top u_dut (
    .clk_i(clk), .rst_ni(rst_n), .enable_i(enable),
    .upd_valid_i(upd_valid), .upd_req_i(upd_req), .upd_rdy_o(req_rdy),
    .upd_rsp_o(upd_rsp), .upd_ack_o(upd_ack), .upd_rdy_i(res_rdy),
    .es_req_i(es_req), .es_ack_o(es_ack),
    .benc_valid_o(benc_valid), .benc_req_o(benc_req), .benc_rdy_i(benc_rdy),
    .benc_ack_i(benc_ack), .benc_rsp_i(benc_rsp), .benc_rdy_o(rsp_rdy)
  );

  drbg_upd_checker u_chk (
    .clk_i(clk), .rst_ni(rst_n), .enable_i(enable),
    .req_valid_i(upd_valid), .req_rdy_i(req_rdy), .req_i(upd_req),
    .ack_i(upd_ack), .rsp_i(upd_rsp), .res_cnt_o(chk_res), .err_cnt_o(chk_err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] rand_word();
    return 32'($random(seed));
  endfunction

  function automatic upd_req_t make_req(input logic near_wrap);
    upd_req_t req;
    int       k;
    req.cmd     = drbg_cmd_e'(3'($unsigned($random(seed)) % 5 + 1));
    req.inst_id = `DRBG_ID_W'(rand_word());
    for (k = 0; k < `DRBG_SEED_W / 32; k++) begin
      req.pdata[k*32 +: 32] = rand_word();
    end
    for (k = 0; k < `DRBG_KEY_W / 32; k++) begin
      req.key[k*32 +: 32] = rand_word();
    end
    for (k = 0; k < `DRBG_BLK_W / 32; k++) begin
      req.v[k*32 +: 32] = rand_word();
    end
    // low word within three of all ones, so the counter wraps
    if (near_wrap) begin
      req.v[`DRBG_CTR_W-1:0] = 32'hffff_fffc | (rand_word() & 32'h3);
    end
    return req;
  endfunction

  function automatic benc_rsp_t cipher_response(input benc_req_t req);
    benc_rsp_t              rsp;
    logic [`DRBG_BLK_W-1:0] x;
    x           = req.v ^ req.key[`DRBG_BLK_W-1:0];
    rsp.cmd     = req.cmd;
    rsp.inst_id = req.inst_id;
    rsp.v       = {x[`DRBG_BLK_W-9:0], x[`DRBG_BLK_W-1 -: 8]};
    return rsp;
  endfunction

  // ------------------------------------------------------------------------
  // cipher stand-in and result back-pressure
  // ------------------------------------------------------------------------

  // what the DUT saw at the rising edge
  always @(posedge clk) begin
    en_seen    = enable;
    benc_taken = enable && benc_valid && benc_rdy;
    rsp_taken  = enable && benc_ack && rsp_rdy;
    taken_req  = benc_req;
  end

  always @(negedge clk) begin
    if (!en_seen) begin
      cipher_q.delete();
      benc_ack  = 1'b0;
      rsp_delay = 0;
    end else begin
      if (benc_taken) begin
        cipher_q.push_back(taken_req);
      end
      if (benc_ack && rsp_taken) begin
        benc_ack  = 1'b0;
        rsp_delay = stress ? ($random(seed) & 7) : 0;
      end else if (!benc_ack && cipher_q.size() > 0) begin
        if (rsp_delay > 0) begin
          rsp_delay--;
        end else begin
          benc_rsp = cipher_response(cipher_q.pop_front());
          benc_ack = 1'b1;
        end
      end
    end
    benc_rdy = stress ? (($random(seed) & 3) != 0) : 1'b1;
    res_rdy  = stress ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // ------------------------------------------------------------------------
  // helpers are called and return on a falling edge
  // ------------------------------------------------------------------------

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("ERR %s exp=%h got=%h", name, want, got);
      tb_err++;
    end
  endtask

  task automatic send_request(input upd_req_t req);
    int cycles;
    cycles    = 0;
    upd_req   = req;
    upd_valid = 1'b1;
    while (!req_rdy && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!req_rdy) begin
      $display("timeout: the request channel never became ready");
      tb_err++;
    end else begin
      expected++;
    end
    @(negedge clk);
    upd_valid = 1'b0;
  endtask

  task automatic wait_results(input string what);
    int cycles;
    cycles = 0;
    while (chk_res < expected && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (chk_res < expected) begin
      $display("timeout: %0d of %0d results seen for %s", chk_res, expected, what);
      tb_err++;
    end
  endtask

  task automatic wait_es_ack(input logic level);
    int cycles;
    cycles = 0;
    while (es_ack !== level && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (es_ack !== level) begin
      $display("timeout: es_ack_o never went to %0d", level);
      tb_err++;
    end
  endtask

  task automatic wait_benc_valid();
    int cycles;
    cycles = 0;
    while (!benc_valid && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!benc_valid) begin
      $display("timeout: no cipher request was issued");
      tb_err++;
    end
  endtask

  task automatic start_test();
    test_errs = tb_err + chk_err;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (tb_err + chk_err != test_errs) begin
      tests_bad++;
      $display("test %0d %s: FAIL", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------

  initial begin
    int i;
    int res_before;
    rst_n     = 1'b0;
    enable    = 1'b1;
    upd_valid = 1'b0;
    upd_req   = '0;
    es_req    = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    start_test();
    check_bit("upd_ack_o", upd_ack, 1'b0);
    check_bit("benc_valid_o", benc_valid, 1'b0);
    check_bit("es_ack_o", es_ack, 1'b0);
    check_bit("upd_rdy_o", req_rdy, 1'b1);
    check_bit("benc_rdy_o", rsp_rdy, 1'b1);
    send_request(make_req(1'b0));
    wait_results("the single request");
    end_test("reset values and single request");

    start_test();
    for (i = 0; i < 40; i++) begin
      send_request(make_req(i % 5 == 4));
    end
    wait_results("forty random requests");
    end_test("random requests with counter wrap");

    start_test();
    stress = 1'b1;
    for (i = 0; i < 30; i++) begin
      send_request(make_req(i % 4 == 3));
    end
    wait_results("requests under back-pressure");
    stress = 1'b0;
    end_test("back-pressure and cipher delays");

    start_test();
    es_req = 1'b1;
    wait_es_ack(1'b1);
    send_request(make_req(1'b0));
    // request sits in its stage while halted
    for (i = 0; i < 10; i++) begin
      check_bit("benc_valid_o", benc_valid, 1'b0);
      check_bit("es_ack_o", es_ack, 1'b1);
      @(negedge clk);
    end
    es_req = 1'b0;
    wait_es_ack(1'b0);
    send_request(make_req(1'b1));
    wait_results("requests after the halt");
    end_test("entropy source halt");

    start_test();
    send_request(make_req(1'b0));
    wait_benc_valid();
    enable = 1'b0;
    expected--;
    repeat (3) @(negedge clk);
    enable = 1'b1;
    // long enough for a surviving update to finish
    res_before = chk_res;
    repeat (40) @(negedge clk);
    if (chk_res != res_before) begin
      $display("a result came out of the request cleared by enable");
      tb_err++;
    end
    send_request(make_req(1'b0));
    wait_results("the request after enable returned");
    repeat (20) @(negedge clk);
    if (chk_res != expected) begin
      $display("%0d results seen where %0d were expected", chk_res, expected);
      tb_err++;
    end
    end_test("enable cleared mid-update");

    $display("tests run %0d, tests with errors %0d, results checked %0d, errors %0d",
             tests_run, tests_bad, chk_res, tb_err + chk_err);
    if (tb_err + chk_err == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
